// File: vlog.f
cpuPkg.sv
exOperandIf.sv
exOperandSelect.sv
aluUnit.sv
branchUnit.sv
exCombine.sv
exStage.sv
exStage_assert.sv
tbExStage.sv

// File: tbExStage.sv
module tbExStage
    import cpuPkg::*;
();

    localparam int DataWidth  = 32;
    localparam int ClkPeriod  = 100;
    localparam int DriveDelay = 10;
    localparam int NumRows    = 18;

    typedef logic [DataWidth-1:0] word_t;

    typedef struct packed
    {
        logic [3:0] gap;        // idle cycles before the issue
        word_t      rs;
        word_t      rt;
        word_t      signExt;
        word_t      pc;
        logic       aluSrc;
        aluOp_t     aluOp;
        logic       branch;
    } row_t;

    typedef struct packed
    {
        logic [7:0] index;
        word_t      result;
        logic       zero;
        logic       taken;
        word_t      pcNext;
    } expect_t;

    logic    clk;
    logic    reset;
    logic    issue;
    word_t   rs;
    word_t   rt;
    word_t   signExt;
    word_t   pc;
    logic    aluSrc;
    aluOp_t  aluOp;
    logic    branch;
    logic    done;
    word_t   result;
    logic    zero;
    logic    branchTaken;
    word_t   pcNext;

    row_t        rows [NumRows];
    expect_t     expQ [$];
    expect_t     observed;
    logic [31:0] lfsrState;
    int          rowCount;
    int          errorCount;
    int          errorsBefore;
    int          testsRun;
    int          cycleLimit;
    logic        tableReady;

    exStage #(.DataWidth(DataWidth)) uut
    (
        .clk         (clk),
        .reset       (reset),
        .issue       (issue),
        .rs          (rs),
        .rt          (rt),
        .signExt     (signExt),
        .pc          (pc),
        .aluSrc      (aluSrc),
        .aluOp       (aluOp),
        .branch      (branch),
        .done        (done),
        .result      (result),
        .zero        (zero),
        .branchTaken (branchTaken),
        .pcNext      (pcNext)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    // right-shift Galois form stepped once per bit
    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        if (state[0])
            return (state >> 1) ^ 32'hB4BC0000;
        return state >> 1;
    endfunction

    task automatic randomWord(output word_t value);
        for (int b = 0; b < DataWidth; b++)
        begin
            value[b]  = lfsrState[0];
            lfsrState = lfsrStep(lfsrState);
        end
    endtask

    // expected outputs straight from the stage rules
    function automatic expect_t referenceModel(input row_t r, input int index);
        expect_t                e;
        word_t                  opB;
        logic [2*DataWidth-1:0] product;
        opB      = r.aluSrc ? r.signExt : r.rt;
        product  = r.rs * opB;
        e.index  = index[7:0];
        e.zero   = (r.rs == opB);
        if (r.aluOp == aluBranch || (r.aluOp == aluRType && r.signExt[5:0] == functSub))
            e.result = r.rs - opB;
        else if (r.aluOp == aluRType && r.signExt[5:0] == functMul)
            e.result = product[DataWidth-1:0];  // low half only
        else
            e.result = r.rs + opB;
        e.taken  = r.branch && e.zero;
        e.pcNext = e.taken ? r.pc + r.signExt * 4 : r.pc;
        return e;
    endfunction

    task automatic compareWord(input string name, input word_t got, input word_t expected);
        if (got !== expected)
        begin
            $display("Error: %s got %h expected %h", name, got, expected);
            errorCount++;
        end
    endtask

    task automatic compareBit(input string name, input logic got, input logic expected);
        if (got !== expected)
        begin
            $display("Error: %s got %h expected %h", name, got, expected);
            errorCount++;
        end
    endtask

    task automatic addRow(input int gap, input logic randOps, input word_t rsVal,
                          input word_t rtVal, input word_t immVal, input word_t pcVal,
                          input logic srcVal, input aluOp_t opVal, input logic branchVal);
        row_t r;
        r.gap     = gap[3:0];
        r.rs      = rsVal;
        r.rt      = rtVal;
        r.signExt = immVal;
        r.pc      = pcVal;
        r.aluSrc  = srcVal;
        r.aluOp   = opVal;
        r.branch  = branchVal;
        if (randOps)
        begin
            randomWord(r.rs);
            randomWord(r.rt);
        end
        rows[rowCount] = r;
        rowCount++;
    endtask

    //     gap rnd rs            rt            imm           pc          src op         br
    task automatic buildTable();
        addRow(0, 0, 32'h64,       32'hffffffff, 32'h14,       32'h100,  1, aluMem,    0);
        addRow(0, 0, 32'hfffffff0, 32'h3,        32'h20,       32'h104,  1, aluMem,    0);
        addRow(2, 0, 32'h5,        32'h7,        32'h0,        32'h108,  0, aluNone,   0);
        addRow(0, 0, 32'h1234,     32'h4321,     32'h0,        32'h10c,  0, aluRType,  0);
        addRow(1, 0, 32'h80000000, 32'h80000001, 32'h25,       32'h110,  0, aluRType,  0);
        addRow(0, 1, 32'h0,        32'h0,        32'h1,        32'h114,  0, aluRType,  0);
        addRow(0, 1, 32'h0,        32'h0,        32'h2,        32'h118,  0, aluRType,  0);
        addRow(3, 1, 32'h0,        32'h0,        32'h2,        32'h11c,  0, aluRType,  0);
        addRow(0, 0, 32'h3,        32'h5,        32'h1,        32'h120,  0, aluRType,  0);
        addRow(0, 0, 32'h40,       32'h99,       32'h40,       32'h124,  1, aluMem,    0);
        addRow(2, 0, 32'hdead,     32'hdead,     32'h1,        32'h128,  0, aluRType,  0);
        addRow(0, 0, 32'h7,        32'h7,        32'h4,        32'h1000, 0, aluBranch, 1);
        addRow(1, 0, 32'h9,        32'h9,        32'hfffffffe, 32'h2000, 0, aluBranch, 1);
        addRow(0, 0, 32'h1,        32'h2,        32'h8,        32'h3000, 0, aluBranch, 1);
        addRow(0, 0, 32'h5,        32'h5,        32'h8,        32'h4000, 0, aluBranch, 0);
        addRow(4, 1, 32'h0,        32'h0,        32'h10,       32'h5000, 0, aluBranch, 1);
        addRow(0, 1, 32'h0,        32'h0,        32'h0,        32'h5004, 0, aluRType,  0);
        addRow(0, 0, 32'hffffffff, 32'hffffffff, 32'h2,        32'h5008, 0, aluRType,  0);
    endtask

    task automatic idleCycle();
        @(posedge clk);
        #DriveDelay;
        issue = 1'b0;
    endtask

    task automatic issueRow(input row_t r);
        @(posedge clk);
        #DriveDelay;
        rs      = r.rs;
        rt      = r.rt;
        signExt = r.signExt;
        pc      = r.pc;
        aluSrc  = r.aluSrc;
        aluOp   = r.aluOp;
        branch  = r.branch;
        issue   = 1'b1;
    endtask

    // outputs are registered on posedge, so look at them half a cycle later
    always @(negedge clk)
    begin
        if (reset)
        begin
            compareBit("done", done, 1'b0);
            compareBit("zero", zero, 1'b0);
            compareBit("branchTaken", branchTaken, 1'b0);
        end
        else if (done)
        begin
            if (expQ.size() == 0)
            begin
                $display("done strobe seen with no instruction in flight");
                errorCount++;
            end
            else
            begin
                observed     = expQ.pop_front();
                errorsBefore = errorCount;
                compareWord("result", result, observed.result);
                compareBit("zero", zero, observed.zero);
                compareBit("branchTaken", branchTaken, observed.taken);
                compareWord("pcNext", pcNext, observed.pcNext);
                testsRun++;
                $display("test %0d: %s", observed.index,
                         (errorCount == errorsBefore) ? "ok" : "FAILED");
            end
        end
    end

    initial
    begin
        clk        = 1'b0;
        reset      = 1'b1;
        issue      = 1'b0;
        rs         = '0;
        rt         = '0;
        signExt    = '0;
        pc         = '0;
        aluSrc     = 1'b0;
        aluOp      = aluNone;
        branch     = 1'b0;
        lfsrState  = 32'h4790;
        rowCount   = 0;
        errorCount = 0;
        testsRun   = 0;
        tableReady = 1'b0;
        buildTable();
        tableReady = 1'b1;

        repeat (4) @(posedge clk);
        #DriveDelay;
        reset = 1'b0;
        @(negedge clk);     // first cycle out of reset with nothing issued yet
        compareBit("done", done, 1'b0);
        compareBit("zero", zero, 1'b0);
        compareBit("branchTaken", branchTaken, 1'b0);
        testsRun++;
        $display("test reset: %s", (errorCount == 0) ? "ok" : "FAILED");

        for (int i = 0; i < NumRows; i++)
        begin
            repeat (rows[i].gap) idleCycle();
            expQ.push_back(referenceModel(rows[i], i));
            issueRow(rows[i]);
        end
        idleCycle();

        while (expQ.size() != 0)
            @(posedge clk);
        repeat (3) @(posedge clk);  // catch any stray done
        #DriveDelay;

        $display("%0d tests finished, %0d errors", testsRun, errorCount);
        if (errorCount == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    // reset, every row with its gaps, pipeline latency and a margin
    initial
    begin
        wait (tableReady);
        cycleLimit = 4 + 2 + 3 + 10;
        for (int i = 0; i < NumRows; i++)
            cycleLimit += rows[i].gap + 1;
        #(cycleLimit * ClkPeriod);
        $display("Timeout after %0d cycles, some issued instructions never finished", cycleLimit);
        $display("Test failures found");
        $finish;
    end

endmodule

// File: exStage_assert.sv
module exStageAssert
(
    input logic clk,
    input logic reset,
    input logic issue,
    input logic done,
    input logic branchTaken
);

    // two register stages between issue and done
    issueGivesDone: assert property (@(posedge clk) disable iff (reset)
        issue |-> ##2 done)
        else $error("issue not followed by done two cycles later");

    doneNeedsIssue: assert property (@(posedge clk) disable iff (reset)
        done |-> $past(issue, 2))
        else $error("done without a matching issue");

    // done register clears on the edge after reset is seen
    doneLowInReset: assert property (@(posedge clk)
        reset |=> !done)
        else $error("done high while reset is active");

    takenOnlyWithDone: assert property (@(posedge clk) disable iff (reset)
        branchTaken |-> done)
        else $error("branchTaken high without done");

endmodule

bind exStage exStageAssert strobeChecks
(
    .clk         (clk),
    .reset       (reset),
    .issue       (issue),
    .done        (done),
    .branchTaken (branchTaken)
);

// File: exStage.sv
module exStage
    import cpuPkg::*;
#(
    parameter int DataWidth = 32
)
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 issue,
    input  logic [DataWidth-1:0] rs,
    input  logic [DataWidth-1:0] rt,
    input  logic [DataWidth-1:0] signExt,
    input  logic [DataWidth-1:0] pc,
    input  logic                 aluSrc,
    input  aluOp_t               aluOp,
    input  logic                 branch,
    output logic                 done,
    output logic [DataWidth-1:0] result,
    output logic                 zero,
    output logic                 branchTaken,
    output logic [DataWidth-1:0] pcNext
);

    logic [DataWidth-1:0] aluResult;
    logic                 aluZero;
    logic [DataWidth-1:0] target;

    // registered operand set, shared by both units
    exOperandIf #(.DataWidth(DataWidth)) opBus ();

    exOperandSelect #(.DataWidth(DataWidth)) operandSelect
    (
        .clk     (clk),
        .reset   (reset),
        .issue   (issue),
        .rs      (rs),
        .rt      (rt),
        .signExt (signExt),
        .pc      (pc),
        .aluSrc  (aluSrc),
        .aluOp   (aluOp),
        .branch  (branch),
        .opBus   (opBus.source)
    );

    // these two run side by side in the same cycle
    aluUnit #(.DataWidth(DataWidth)) alu
    (
        .opBus  (opBus.sink),
        .result (aluResult),
        .zero   (aluZero)
    );

    branchUnit #(.DataWidth(DataWidth)) branchTarget
    (
        .opBus  (opBus.sink),
        .target (target)
    );

    exCombine #(.DataWidth(DataWidth)) combine
    (
        .clk         (clk),
        .reset       (reset),
        .opBus       (opBus.sink),
        .aluResult   (aluResult),
        .aluZero     (aluZero),
        .target      (target),
        .done        (done),
        .result      (result),
        .zero        (zero),
        .branchTaken (branchTaken),
        .pcNext      (pcNext)
    );

endmodule

// File: exCombine.sv
module exCombine
#(
    parameter int DataWidth = 32
)
(
    input  logic                 clk,
    input  logic                 reset,
    exOperandIf.sink             opBus,
    input  logic [DataWidth-1:0] aluResult,
    input  logic                 aluZero,
    input  logic [DataWidth-1:0] target,
    output logic                 done,
    output logic [DataWidth-1:0] result,
    output logic                 zero,
    output logic                 branchTaken,
    output logic [DataWidth-1:0] pcNext
);

    logic                 taken;
    logic [DataWidth-1:0] pcSelect;

    // beq: take it only when the operands matched
    assign taken = opBus.branch & aluZero;

    always_comb
    begin
        if (taken)
        begin
            pcSelect = target;
        end
        else
        begin
            pcSelect = opBus.pc;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            done        <= 1'b0;
            result      <= '0;
            zero        <= 1'b0;
            branchTaken <= 1'b0;
            pcNext      <= '0;
        end
        else
        begin
            done        <= opBus.valid;
            branchTaken <= opBus.valid & taken;     // never outlives done
            if (opBus.valid)
            begin
                result <= aluResult;
                zero   <= aluZero;
                pcNext <= pcSelect;
            end
        end
    end

endmodule

// File: branchUnit.sv
module branchUnit
#(
    parameter int DataWidth = 32
)
(
    exOperandIf.sink             opBus,
    output logic [DataWidth-1:0] target
);

    logic [DataWidth-1:0] wordOffset;

    // immediate counts words, so scale to bytes
    assign wordOffset = opBus.signExt << 2;

    // computed every cycle, exCombine decides whether it is used
    assign target = opBus.pc + wordOffset;  // wraps at DataWidth

endmodule

// File: aluUnit.sv
module aluUnit
    import cpuPkg::*;
#(
    parameter int DataWidth = 32
)
(
    exOperandIf.sink             opBus,
    output logic [DataWidth-1:0] result,
    output logic                 zero
);

    logic [5:0] funct;
    aluCtrl_t   aluCtrl;

    assign funct = opBus.signExt[5:0];  // R-type funct rides in the immediate

    // ALU control decode
    always_comb
    begin
        case (opBus.aluOp)
            aluMem, aluNone:
            begin
                aluCtrl = ctrlAdd;
            end
            aluBranch:
            begin
                aluCtrl = ctrlSub;
            end
            aluRType:
            begin
                case (funct)
                    functAdd: aluCtrl = ctrlAdd;
                    functSub: aluCtrl = ctrlSub;
                    functMul: aluCtrl = ctrlMul;
                    default:  aluCtrl = ctrlAdd;    // unknown funct acts as add
                endcase
            end
            default:
            begin
                aluCtrl = ctrlAdd;
            end
        endcase
    end

    // result wraps at DataWidth, product keeps only the low half
    always_comb
    begin
        case (aluCtrl)
            ctrlSub:
            begin
                result = opBus.data1 - opBus.data2;
            end
            ctrlMul:
            begin
                result = opBus.data1 * opBus.data2;
            end
            default:
            begin
                result = opBus.data1 + opBus.data2;
            end
        endcase
    end

    // equality straight from the operands, independent of the op
    assign zero = (opBus.data1 == opBus.data2);

endmodule

// File: exOperandSelect.sv
module exOperandSelect
    import cpuPkg::*;
#(
    parameter int DataWidth = 32
)
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 issue,
    input  logic [DataWidth-1:0] rs,
    input  logic [DataWidth-1:0] rt,
    input  logic [DataWidth-1:0] signExt,
    input  logic [DataWidth-1:0] pc,
    input  logic                 aluSrc,
    input  aluOp_t               aluOp,
    input  logic                 branch,
    exOperandIf.source           opBus
);

    logic [DataWidth-1:0] secondOperand;

    // aluSrc high picks the immediate, as for lw/sw/addi
    always_comb
    begin
        if (aluSrc)
        begin
            secondOperand = signExt;
        end
        else
        begin
            secondOperand = rt;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            opBus.valid <= 1'b0;
        end
        else
        begin
            opBus.valid <= issue;   // high for exactly one cycle per issue
        end
    end

    // payload only moves on issue
    always_ff @(posedge clk)
    begin
        if (issue)
        begin
            opBus.data1   <= rs;
            opBus.data2   <= secondOperand;
            opBus.signExt <= signExt;
            opBus.pc      <= pc;
            opBus.aluOp   <= aluOp;
            opBus.branch  <= branch;
        end
    end

endmodule

// File: exOperandIf.sv
interface exOperandIf
    import cpuPkg::*;
#(
    parameter int DataWidth = 32
);

    logic                 valid;    // one cycle per issued instruction
    logic [DataWidth-1:0] data1;
    logic [DataWidth-1:0] data2;    // already muxed between rt and immediate
    logic [DataWidth-1:0] signExt;
    logic [DataWidth-1:0] pc;
    aluOp_t               aluOp;
    logic                 branch;

    // operand stage drives the bundle
    modport source
    (
        output valid,
        output data1,
        output data2,
        output signExt,
        output pc,
        output aluOp,
        output branch
    );

    // ALU, branch and combine blocks only read it
    modport sink
    (
        input valid,
        input data1,
        input data2,
        input signExt,
        input pc,
        input aluOp,
        input branch
    );

endinterface

// File: cpuPkg.sv
package cpuPkg;

    // operation class from the decoder
    typedef enum logic [1:0]
    {
        aluMem    = 2'b00,  // lw, sw, addi
        aluBranch = 2'b01,  // beq compares by subtracting
        aluRType  = 2'b10,  // look at funct
        aluNone   = 2'b11   // no real op, falls back to add
    } aluOp_t;

    // what the ALU actually computes
    typedef enum logic [3:0]
    {
        ctrlAdd = 4'b0000,
        ctrlSub = 4'b0001,
        ctrlMul = 4'b0010
    } aluCtrl_t;

    // function codes, taken from the low six bits of the immediate
    localparam logic [5:0] functAdd = 6'd0;
    localparam logic [5:0] functSub = 6'd1;
    localparam logic [5:0] functMul = 6'd2;

endpackage
